/* Makefile */
# Verilator build and run of the OPL timer subsystem testbench

VERILATOR ?= verilator
TOP       ?= opl_timers_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard verilog/*.sv) $(wildcard tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
verilog/opl_timer_pkg.sv
verilog/opl_clk_div.sv
verilog/opl_reg_decode.sv
verilog/opl_timer.sv
verilog/opl_status.sv
verilog/opl_timers_top.sv
tests/tb_clk_gen.sv
tests/opl_timers_checker.sv
tests/opl_timers_asserts.sv
tests/opl_timers_tb.sv

/* tests/opl_timers_asserts.sv */
// concurrent checks on the top level outputs
// sample pulse width, irq pin polarity, unused status bits
`timescale 1ns/1ns
`default_nettype none

module opl_timers_asserts (
    input logic       clk,
    input logic       rst,
    input logic       sample,
    input logic [7:0] dout,
    input logic       irq_n
);

    // count of failed checks
    int fail_cnt = 0;

    sample_one_cycle: assert property (
        @(posedge clk) disable iff (rst) sample |=> !sample
    ) else begin
        $error("sample strobe longer than one cycle");
        fail_cnt++;
    end

    irq_matches_status: assert property (
        @(posedge clk) disable iff (rst) irq_n == !dout[7]
    ) else begin
        $error("irq_n does not match status bit 7");
        fail_cnt++;
    end

    low_bits_zero: assert property (
        @(posedge clk) disable iff (rst) dout[4:0] == 5'b00000
    ) else begin
        $error("status bits 4 to 0 not zero");
        fail_cnt++;
    end

endmodule

bind opl_timers_top opl_timers_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .sample (sample),
    .dout   (dout),
    .irq_n  (irq_n)
);

`default_nettype wire

/* tests/opl_timers_checker.sv */
// reference model of timebase, registers, timers and flags
// compares sample, dout and irq_n every cycle
`timescale 1ns/1ns
`default_nettype none

module opl_timers_checker
    import opl_timer_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cen,
    input  logic [7:0]   din,
    input  logic         addr,
    input  logic         write,
    input  logic         sample,
    input  logic [7:0]   dout,
    input  logic         irq_n,
    input  logic [127:0] test_name,
    output int           errors
);

    int         cen_c;
    int         slot_c;
    logic [7:0] sel;
    logic [7:0] value [2];
    logic       load [2];
    logic       load_d [2];
    logic       flag_en [2];
    logic       clr;
    logic [7:0] cnt [2];
    int         pre [2];
    logic       ovf [2];
    logic       flag [2];
    logic       cenop_m;
    logic       zero_m;
    logic [7:0] exp_dout;
    int         err_cnt = 0;

    assign errors = err_cnt;

    // expected strobes from the cen count
    always_comb begin
        cenop_m = cen && (cen_c == OPL_CEN_DIV - 1);
        zero_m  = cenop_m && (slot_c == OPL_SLOTS - 1);
    end

    function automatic int prescale_of(int i);
        return (i == 0) ? TIMER_A_PRESCALE : TIMER_B_PRESCALE;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            cen_c  <= 0;
            slot_c <= 0;
            sel    <= 8'h00;
            clr    <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                value[i]   <= 8'h00;
                load[i]    <= 1'b0;
                load_d[i]  <= 1'b0;
                flag_en[i] <= 1'b1;
                cnt[i]     <= 8'h00;
                pre[i]     <= 0;
                ovf[i]     <= 1'b0;
                flag[i]    <= 1'b0;
            end
        end else begin
            if (cen) begin
                cen_c <= (cen_c == OPL_CEN_DIV - 1) ? 0 : cen_c + 1;
            end
            if (cenop_m) begin
                slot_c <= (slot_c == OPL_SLOTS - 1) ? 0 : slot_c + 1;
            end
            // host writes, clear bit ends on a quiet cenop
            if (write && !addr) begin
                sel <= din;
            end else if (write) begin
                if (sel == reg_timer_a) begin
                    value[0] <= din;
                end else if (sel == reg_timer_b) begin
                    value[1] <= din;
                end else if (sel == reg_timer_ctl) begin
                    clr        <= din[7];
                    flag_en[0] <= !din[6];
                    flag_en[1] <= !din[5];
                    load[0]    <= din[0];
                    load[1]    <= din[1];
                end
            end else if (cenop_m) begin
                clr <= 1'b0;
            end
            for (int i = 0; i < 2; i++) begin
                load_d[i] <= load[i];
                ovf[i]    <= 1'b0;
                if (load[i] && !load_d[i]) begin
                    cnt[i] <= value[i];
                    pre[i] <= 0;
                end else if (load[i] && zero_m) begin
                    if (pre[i] == prescale_of(i) - 1) begin
                        pre[i] <= 0;
                        // wrap past 255 reloads
                        if (cnt[i] == 8'hff) begin
                            cnt[i] <= value[i];
                            ovf[i] <= 1'b1;
                        end else begin
                            cnt[i] <= cnt[i] + 8'd1;
                        end
                    end else begin
                        pre[i] <= pre[i] + 1;
                    end
                end
                // set wins over clear
                flag[i] <= (ovf[i] && flag_en[i]) || (flag[i] && !clr);
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            exp_dout = {flag[0] | flag[1], flag[0], flag[1], 5'b00000};
            if (dout !== exp_dout) begin
                $display("MISMATCH %0s dout expected %02h actual %02h",
                         test_name, exp_dout, dout);
                err_cnt++;
            end
            if (irq_n !== !(flag[0] | flag[1])) begin
                $display("MISMATCH %0s irq_n expected %0b actual %0b",
                         test_name, !(flag[0] | flag[1]), irq_n);
                err_cnt++;
            end
            if (sample !== zero_m) begin
                $display("MISMATCH %0s sample expected %0b actual %0b",
                         test_name, zero_m, sample);
                err_cnt++;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/opl_timers_tb.sv */
// testbench top for the OPL timer subsystem
// stimulus table, DUT, checker, watchdog and closing report
`timescale 1ns/1ns
`default_nettype none

module opl_timers_tb
    import opl_timer_pkg::*;
;

    typedef struct packed {
        logic [127:0] name;
        logic         cen_half;
        logic [7:0]   rnum;
        logic [7:0]   data;
        logic [15:0]  waits;
    } entry_t;

    localparam int N_ENTRIES = 13;

    logic         clk;
    logic         rst;
    logic         cen;
    logic [7:0]   din;
    logic         addr;
    logic         write;
    logic [7:0]   dout;
    logic         irq_n;
    logic         sample;
    logic         cen_half;
    logic [127:0] cur_name;
    int           errors;
    int           seed;
    entry_t       tbl [N_ENTRIES];

    tb_clk_gen #(.period(20), .rst_cycles(16)) u_clk (.clk(clk), .rst(rst));

    opl_timers_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .write  (write),
        .dout   (dout),
        .irq_n  (irq_n),
        .sample (sample)
    );

    opl_timers_checker u_check (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .din       (din),
        .addr      (addr),
        .write     (write),
        .sample    (sample),
        .dout      (dout),
        .irq_n     (irq_n),
        .test_name (cur_name),
        .errors    (errors)
    );

    // cen every cycle or every other cycle
    always @(posedge clk) begin
        #2 cen <= cen_half ? ~cen : 1'b1;
    end

    task automatic set_entry(int i, logic [127:0] n, logic h, logic [7:0] r,
                             logic [7:0] d, int w);
        tbl[i] = '{name: n, cen_half: h, rnum: r, data: d, waits: 16'(w)};
    endtask

    task automatic host_write(logic a, logic [7:0] d);
        @(posedge clk);
        #2;
        write = 1'b1;
        addr  = a;
        din   = d;
        @(posedge clk);
        #2;
        write = 1'b0;
    endtask

    task automatic wait_samples(int n);
        int k;
        k = 0;
        while (k < n) begin
            @(posedge clk);
            if (sample) k++;
        end
    endtask

    initial begin
        cen      = 1'b0;
        din      = 8'h00;
        addr     = 1'b0;
        write    = 1'b0;
        cen_half = 1'b0;
        cur_name = "reset";
        seed     = 32'hedd332e5;
        set_entry(0,  "idle_full_cen", 1'b0, 8'h10, 8'h00, 3);
        set_entry(1,  "idle_half_cen", 1'b1, 8'h11, 8'h00, 2);
        set_entry(2,  "ta_value_fa",   1'b0, reg_timer_a, 8'hfa, 0);
        set_entry(3,  "ta_start",      1'b0, reg_timer_ctl, 8'h01, 14);
        set_entry(4,  "ta_value_fe",   1'b0, reg_timer_a, 8'hfe, 6);
        set_entry(5,  "clear_flags",   1'b0, reg_timer_ctl, 8'h81, 8);
        set_entry(6,  "tb_value_fc",   1'b0, reg_timer_b, 8'hfc, 0);
        set_entry(7,  "ta_tb_run",     1'b0, reg_timer_ctl, 8'h03, 20);
        set_entry(8,  "mask_a",        1'b0, reg_timer_ctl, 8'hc3, 20);
        set_entry(9,  "mask_b",        1'b0, reg_timer_ctl, 8'ha3, 20);
        set_entry(10, "stop_timers",   1'b0, reg_timer_ctl, 8'h80, 30);
        set_entry(11, "unused_reg",    1'b0, 8'h05, 8'hff, 4);
        set_entry(12, "half_cen_run",  1'b1, reg_timer_ctl, 8'h01, 8);
        @(negedge rst);
        repeat (2) @(posedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            cur_name = tbl[i].name;
            cen_half = tbl[i].cen_half;
            host_write(1'b0, tbl[i].rnum);
            // random idle gap between address and data
            repeat ($unsigned($random(seed)) % 4) @(posedge clk);
            host_write(1'b1, tbl[i].data);
            wait_samples(int'(tbl[i].waits));
        end
        repeat (4) @(posedge clk);
        $display("run complete, %0d mismatches, %0d assertion failures",
                 errors, u_dut.u_asserts.fail_cnt);
        if (errors == 0 && u_dut.u_asserts.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // limit from the table waits with two clk per cen pulse at worst
    initial begin
        int limit;
        limit = 2000;
        @(negedge rst);
        for (int i = 0; i < N_ENTRIES; i++) begin
            limit += (int'(tbl[i].waits) + 2) * OPL_CEN_DIV * OPL_SLOTS * 2;
        end
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, sample strobes stopped", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
// testbench clock and reset source
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int period     = 20,
    parameter int rst_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    // reset held for a fixed number of edges
    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verilog/opl_clk_div.sv */
// timebase divider
// cen to operator strobe (cenop) and sample strobe (zero)
`timescale 1ns/1ns
`default_nettype none

module opl_clk_div
    import opl_timer_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic cenop,
    output logic zero
);

    logic [CEN_CNT_W-1:0]  cen_cnt;
    logic [SLOT_CNT_W-1:0] slot_cnt;
    logic                  cen_last;
    logic                  slot_last;

    // last phase of each counter
    assign cen_last  = cen_cnt == CEN_CNT_W'(OPL_CEN_DIV - 1);
    assign slot_last = slot_cnt == SLOT_CNT_W'(OPL_SLOTS - 1);

    // strobes straight from the counters, no extra latency
    assign cenop = cen & cen_last;
    // sample tick on the last slot
    assign zero  = cenop & slot_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt  <= '0;
            slot_cnt <= '0;
        end else begin
            // cen phase counter
            if (cen) begin
                cen_cnt <= cen_last ? '0 : cen_cnt + 1'b1;
            end
            // slot counter, one step per operator strobe
            if (cenop) begin
                slot_cnt <= slot_last ? '0 : slot_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/opl_reg_decode.sv */
// host register port
// address 0 selects a register, address 1 writes it
// timer values, load bits, flag masks and the one-shot flag clear
`timescale 1ns/1ns
`default_nettype none

module opl_reg_decode
    import opl_timer_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            cenop,
    input  logic [7:0]      din,
    input  logic            addr,
    input  logic            write,
    output timer_ctl_pair_t ctl
);

    // register number latched from address 0
    logic [7:0] sel_reg;

    // control register field decode
    logic       wr_clr;
    logic       wr_mask_a;
    logic       wr_mask_b;
    logic       wr_load_a;
    logic       wr_load_b;

    assign wr_clr    = din[7];
    assign wr_mask_a = din[6];
    assign wr_mask_b = din[5];
    // bits 4..2 have no function here
    assign wr_load_b = din[1];
    assign wr_load_a = din[0];

    // runs every clk, writes are not gated by cen
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg           <= 8'h00;
            ctl.a.value       <= 8'h00;
            ctl.a.load        <= 1'b0;
            ctl.a.flag_en     <= 1'b1;
            ctl.b.value       <= 8'h00;
            ctl.b.load        <= 1'b0;
            ctl.b.flag_en     <= 1'b1;
            ctl.clr_flag      <= 1'b0;
        end else begin
            if (write) begin
                if (!addr) begin
                    // address phase
                    sel_reg <= din;
                end else begin
                    // data phase, selected register only
                    case (sel_reg)
                        reg_timer_a: begin
                            ctl.a.value <= din;
                        end
                        reg_timer_b: begin
                            ctl.b.value <= din;
                        end
                        reg_timer_ctl: begin
                            // clear request applies to both flags
                            ctl.clr_flag  <= wr_clr;
                            // mask bits are active high on the bus
                            ctl.a.flag_en <= ~wr_mask_a;
                            ctl.b.flag_en <= ~wr_mask_b;
                            ctl.a.load    <= wr_load_a;
                            ctl.b.load    <= wr_load_b;
                        end
                        default: begin
                            // unknown registers are ignored
                        end
                    endcase
                end
            end else if (cenop) begin
                // once-only bit, drops on the next quiet operator strobe
                ctl.clr_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/opl_status.sv */
// timer status flags and interrupt
// flag set, mask and clear, status byte readback
`timescale 1ns/1ns
`default_nettype none

module opl_status
    import opl_timer_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  timer_ctl_pair_t ctl,
    input  timer_evt_t      evt,
    output logic [7:0]      dout,
    output logic            irq_n
);

    logic flag_a;
    logic flag_b;
    logic flag_a_nx;
    logic flag_b_nx;
    logic irq_nx;
    logic set_a;
    logic set_b;

    // masked overflow only sets its flag
    assign set_a = evt.overflow_a & ctl.a.flag_en;
    assign set_b = evt.overflow_b & ctl.b.flag_en;

    // set wins over a clear in the same cycle
    always_comb begin
        flag_a_nx = set_a | (flag_a & ~ctl.clr_flag);
        flag_b_nx = set_b | (flag_b & ~ctl.clr_flag);
        irq_nx    = flag_a_nx | flag_b_nx;
    end

    // flags, byte and interrupt all update on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            dout   <= 8'h00;
            irq_n  <= 1'b1;
        end else begin
            flag_a <= flag_a_nx;
            flag_b <= flag_b_nx;
            // bit 7 irq, bit 6 flag a, bit 5 flag b
            dout   <= {irq_nx, flag_a_nx, flag_b_nx, 5'b00000};
            // pin is active low
            irq_n  <= ~irq_nx;
        end
    end

endmodule

`default_nettype wire

/* verilog/opl_timer.sv */
// reloadable 8-bit up-counting timer
// counts sample strobes through a prescaler
// one-cycle overflow pulse on each wrap
`timescale 1ns/1ns
`default_nettype none

module opl_timer
    import opl_timer_pkg::*;
#(
    // sample strobes per count, at most TIMER_B_PRESCALE
    parameter int prescale = TIMER_A_PRESCALE
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       zero,
    input  timer_ctl_t ctl,
    output logic       overflow
);

    logic [7:0]             cnt;
    logic [TIMER_PRE_W-1:0] pre_cnt;
    logic                   load_d;
    logic                   load_rise;
    logic                   pre_last;
    logic                   tick;
    logic                   wrap;

    // start of a run
    assign load_rise = ctl.load & ~load_d;

    // prescaler terminal phase, always true for prescale 1
    assign pre_last  = pre_cnt == TIMER_PRE_W'(prescale - 1);

    // one count step
    assign tick      = ctl.load & zero & pre_last;

    // the step that would pass 255
    assign wrap      = cnt == 8'hff;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_d   <= 1'b0;
            cnt      <= 8'h00;
            pre_cnt  <= '0;
            overflow <= 1'b0;
        end else begin
            load_d   <= ctl.load;
            // pulse by default low
            overflow <= 1'b0;
            if (load_rise) begin
                // preload and restart the prescaler
                cnt     <= ctl.value;
                pre_cnt <= '0;
            end else if (ctl.load && zero) begin
                // prescaler advance
                pre_cnt <= pre_last ? '0 : pre_cnt + 1'b1;
                if (tick) begin
                    if (wrap) begin
                        // reload from the current value register
                        cnt      <= ctl.value;
                        overflow <= 1'b1;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
            end
            // load low holds the count
        end
    end

endmodule

`default_nettype wire

/* verilog/opl_timer_pkg.sv */
// shared constants and types for the OPL timer subsystem
// register numbers, timebase divider and timer prescale values
// packed control and event buses
`default_nettype none

package opl_timer_pkg;

    // register numbers behind address 1
    localparam logic [7:0] reg_timer_a   = 8'h02;
    localparam logic [7:0] reg_timer_b   = 8'h03;
    localparam logic [7:0] reg_timer_ctl = 8'h04;

    // cen pulses per operator strobe
    localparam int OPL_CEN_DIV = 4;
    // operator slots per sample
    localparam int OPL_SLOTS   = 18;

    // counter widths of the timebase
    localparam int CEN_CNT_W  = $clog2(OPL_CEN_DIV);
    localparam int SLOT_CNT_W = $clog2(OPL_SLOTS);

    // sample strobes per timer count
    localparam int TIMER_A_PRESCALE = 1;
    localparam int TIMER_B_PRESCALE = 4;
    // prescaler width, sized for the slower timer
    localparam int TIMER_PRE_W = $clog2(TIMER_B_PRESCALE);

    // controls of one timer
    typedef struct packed {
        logic [7:0] value;
        logic       load;
        logic       flag_en;
    } timer_ctl_t;

    // everything the register block hands to the timers and status
    typedef struct packed {
        timer_ctl_t a;
        timer_ctl_t b;
        logic       clr_flag;
    } timer_ctl_pair_t;

    // one-cycle wrap pulses from the timers
    typedef struct packed {
        logic overflow_a;
        logic overflow_b;
    } timer_evt_t;

endpackage

`default_nettype wire

/* verilog/opl_timers_top.sv */
// OPL timer subsystem top level
// timebase, register port, timers A and B, status block
`timescale 1ns/1ns
`default_nettype none

module opl_timers_top
    import opl_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic       addr,
    input  logic       write,
    output logic [7:0] dout,
    output logic       irq_n,
    output logic       sample
);

    // timebase strobes
    logic            cenop;
    logic            zero;

    // register block to timers and status
    timer_ctl_pair_t ctl;

    // timer wrap pulses
    logic            ovf_a;
    logic            ovf_b;
    timer_evt_t      evt;

    assign evt.overflow_a = ovf_a;
    assign evt.overflow_b = ovf_b;

    // sample-rate tick for the outside world
    assign sample = zero;

    opl_clk_div u_div (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cenop (cenop),
        .zero  (zero)
    );

    opl_reg_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .cenop (cenop),
        .din   (din),
        .addr  (addr),
        .write (write),
        .ctl   (ctl)
    );

    // timer A counts every sample
    opl_timer #(
        .prescale (TIMER_A_PRESCALE)
    ) u_timer_a (
        .clk      (clk),
        .rst      (rst),
        .zero     (zero),
        .ctl      (ctl.a),
        .overflow (ovf_a)
    );

    // timer B counts every fourth sample
    opl_timer #(
        .prescale (TIMER_B_PRESCALE)
    ) u_timer_b (
        .clk      (clk),
        .rst      (rst),
        .zero     (zero),
        .ctl      (ctl.b),
        .overflow (ovf_b)
    );

    opl_status u_status (
        .clk   (clk),
        .rst   (rst),
        .ctl   (ctl),
        .evt   (evt),
        .dout  (dout),
        .irq_n (irq_n)
    );

endmodule

`default_nettype wire
